// File: hdl/zk_defs.svh
`ifndef ZK_DEFS_SVH
`define ZK_DEFS_SVH

// operand and result width of the unit.
`define ZK_XLEN 32

// width of the opcode field seen by the ALU decoder.
`define ZK_OP_W 7

// lane widths used by the permutation logic.
`define ZK_BYTE_W 8
`define ZK_NIB_W 4

`endif

// File: hdl/zk_pkg.sv
`default_nettype none

`include "zk_defs.svh"

package zk_pkg;

	// opcode numbers follow the core's ALU operator encoding.
	typedef enum logic [`ZK_OP_W-1:0] {
		ZK_OP_RORI        = 7'd62,
		ZK_OP_BREV8       = 7'd63,
		ZK_OP_REV8        = 7'd64,
		ZK_OP_ZIP         = 7'd65,
		ZK_OP_UNZIP       = 7'd66,
		ZK_OP_ROR         = 7'd67,
		ZK_OP_ROL         = 7'd68,
		ZK_OP_ANDN        = 7'd69,
		ZK_OP_ORN         = 7'd70,
		ZK_OP_XNOR        = 7'd71,
		ZK_OP_PACK        = 7'd72,
		ZK_OP_PACKH       = 7'd73,
		ZK_OP_XPERM8      = 7'd76,
		ZK_OP_XPERM4      = 7'd77,
		ZK_OP_SHA256_SUM0 = 7'd78,
		ZK_OP_SHA256_SUM1 = 7'd79,
		ZK_OP_SHA256_SIG0 = 7'd80,
		ZK_OP_SHA256_SIG1 = 7'd81,
		ZK_OP_SM3_P0      = 7'd112,
		ZK_OP_SM3_P1      = 7'd113
	} zk_op_e;

	typedef enum logic [1:0] {
		ZK_GRP_NONE,
		ZK_GRP_LOGIC,
		ZK_GRP_PERM,
		ZK_GRP_HASH
	} zk_grp_e;

endpackage

`default_nettype wire

// File: hdl/zk_rotate_logic.sv
`timescale 1ns/1ps
`default_nettype none

`include "zk_defs.svh"

module zk_rotate_logic (
	input wire zk_pkg::zk_op_e operator_i,
	input wire [`ZK_XLEN-1:0] operand_a_i,
	input wire [`ZK_XLEN-1:0] operand_b_i,
	output logic [`ZK_XLEN-1:0] result_o
);

	localparam int SHW = $clog2(`ZK_XLEN);

	// logarithmic barrel rotator, one stage per bit of the amount.
	function automatic logic [`ZK_XLEN-1:0] barrel_rot(
		input logic [`ZK_XLEN-1:0] x,
		input logic [SHW-1:0] amt,
		input logic left
	);
		logic [`ZK_XLEN-1:0] stage;
		int sh;
		stage = x;
		for (int k = 0; k < SHW; k++)
		begin
			sh = 1 << k;
			if (amt[k])
			begin
				if (left)
					stage = (stage << sh) | (stage >> (`ZK_XLEN - sh));
				else
					stage = (stage >> sh) | (stage << (`ZK_XLEN - sh));
			end
		end
		return stage;
	endfunction

	logic [SHW-1:0] shamt;
	logic [`ZK_XLEN-1:0] wror;
	logic [`ZK_XLEN-1:0] wrol;
	logic [`ZK_XLEN-1:0] b_inv;

	assign shamt = operand_b_i[SHW-1:0];
	assign wror = barrel_rot(operand_a_i, shamt, 1'b0);
	assign wrol = barrel_rot(operand_a_i, shamt, 1'b1);
	assign b_inv = ~operand_b_i;

	always_comb
	begin
		case (operator_i)
			zk_pkg::ZK_OP_ROR,
			zk_pkg::ZK_OP_RORI: result_o = wror; // rori carries its immediate in operand b.
			zk_pkg::ZK_OP_ROL:  result_o = wrol;
			zk_pkg::ZK_OP_ANDN: result_o = operand_a_i & b_inv;
			zk_pkg::ZK_OP_ORN:  result_o = operand_a_i | b_inv;
			zk_pkg::ZK_OP_XNOR: result_o = operand_a_i ^ b_inv;
			default:            result_o = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: hdl/zk_permute.sv
`timescale 1ns/1ps
`default_nettype none

`include "zk_defs.svh"

module zk_permute (
	input wire zk_pkg::zk_op_e operator_i,
	input wire [`ZK_XLEN-1:0] operand_a_i,
	input wire [`ZK_XLEN-1:0] operand_b_i,
	output logic [`ZK_XLEN-1:0] result_o
);

	localparam int HALF = `ZK_XLEN / 2;
	localparam int NBYTES = `ZK_XLEN / `ZK_BYTE_W;
	localparam int NNIBS = `ZK_XLEN / `ZK_NIB_W;

	function automatic logic [`ZK_XLEN-1:0] brev8(input logic [`ZK_XLEN-1:0] x);
		logic [`ZK_XLEN-1:0] r;
		for (int i = 0; i < NBYTES; i++)
			for (int j = 0; j < `ZK_BYTE_W; j++)
				r[i*`ZK_BYTE_W + j] = x[i*`ZK_BYTE_W + (`ZK_BYTE_W - 1 - j)];
		return r;
	endfunction

	function automatic logic [`ZK_XLEN-1:0] rev8(input logic [`ZK_XLEN-1:0] x);
		logic [`ZK_XLEN-1:0] r;
		for (int i = 0; i < NBYTES; i++)
			r[i*`ZK_BYTE_W +: `ZK_BYTE_W] = x[(NBYTES - 1 - i)*`ZK_BYTE_W +: `ZK_BYTE_W];
		return r;
	endfunction

	// lower-half bits go to the even positions.
	function automatic logic [`ZK_XLEN-1:0] zip(input logic [`ZK_XLEN-1:0] x);
		logic [`ZK_XLEN-1:0] r;
		for (int i = 0; i < HALF; i++)
		begin
			r[2*i] = x[i];
			r[2*i + 1] = x[i + HALF];
		end
		return r;
	endfunction

	function automatic logic [`ZK_XLEN-1:0] unzip(input logic [`ZK_XLEN-1:0] x);
		logic [`ZK_XLEN-1:0] r;
		for (int i = 0; i < HALF; i++)
		begin
			r[i] = x[2*i];
			r[i + HALF] = x[2*i + 1];
		end
		return r;
	endfunction

	function automatic logic [`ZK_XLEN-1:0] xperm4(
		input logic [`ZK_XLEN-1:0] tbl,
		input logic [`ZK_XLEN-1:0] idx
	);
		logic [`ZK_XLEN-1:0] r;
		logic [`ZK_NIB_W-1:0] sel;
		r = '0;
		for (int i = 0; i < NNIBS; i++)
		begin
			sel = idx[i*`ZK_NIB_W +: `ZK_NIB_W];
			if (sel < NNIBS) // indices past the table read as zero.
				r[i*`ZK_NIB_W +: `ZK_NIB_W] = tbl[sel*`ZK_NIB_W +: `ZK_NIB_W];
		end
		return r;
	endfunction

	function automatic logic [`ZK_XLEN-1:0] xperm8(
		input logic [`ZK_XLEN-1:0] tbl,
		input logic [`ZK_XLEN-1:0] idx
	);
		logic [`ZK_XLEN-1:0] r;
		logic [`ZK_BYTE_W-1:0] sel;
		r = '0;
		for (int i = 0; i < NBYTES; i++)
		begin
			sel = idx[i*`ZK_BYTE_W +: `ZK_BYTE_W];
			if (sel < NBYTES)
				r[i*`ZK_BYTE_W +: `ZK_BYTE_W] = tbl[sel*`ZK_BYTE_W +: `ZK_BYTE_W];
		end
		return r;
	endfunction

	always_comb
	begin
		case (operator_i)
			zk_pkg::ZK_OP_PACK:   result_o = {operand_b_i[HALF-1:0], operand_a_i[HALF-1:0]};
			zk_pkg::ZK_OP_PACKH:  result_o = {{(`ZK_XLEN - 2*`ZK_BYTE_W){1'b0}},
				operand_b_i[`ZK_BYTE_W-1:0], operand_a_i[`ZK_BYTE_W-1:0]};
			zk_pkg::ZK_OP_BREV8:  result_o = brev8(operand_a_i);
			zk_pkg::ZK_OP_REV8:   result_o = rev8(operand_a_i);
			zk_pkg::ZK_OP_ZIP:    result_o = zip(operand_a_i);
			zk_pkg::ZK_OP_UNZIP:  result_o = unzip(operand_a_i);
			zk_pkg::ZK_OP_XPERM4: result_o = xperm4(operand_a_i, operand_b_i);
			zk_pkg::ZK_OP_XPERM8: result_o = xperm8(operand_a_i, operand_b_i);
			default:              result_o = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: hdl/zk_hash_sigma.sv
`timescale 1ns/1ps
`default_nettype none

`include "zk_defs.svh"

module zk_hash_sigma (
	input wire zk_pkg::zk_op_e operator_i,
	input wire [`ZK_XLEN-1:0] operand_a_i,
	input wire [`ZK_XLEN-1:0] operand_b_i,
	output logic [`ZK_XLEN-1:0] result_o
);

	// rotate right by a constant distance.
	function automatic logic [`ZK_XLEN-1:0] rotr(input logic [`ZK_XLEN-1:0] x, input int n);
		return (x >> n) | (x << (`ZK_XLEN - n));
	endfunction

	logic [`ZK_XLEN-1:0] a;
	logic unused_b;

	assign a = operand_a_i;
	assign unused_b = ^operand_b_i; // all hash functions here are unary.

	always_comb
	begin
		case (operator_i)
			zk_pkg::ZK_OP_SHA256_SUM0: result_o = rotr(a, 2) ^ rotr(a, 13) ^ rotr(a, 22);
			zk_pkg::ZK_OP_SHA256_SUM1: result_o = rotr(a, 6) ^ rotr(a, 11) ^ rotr(a, 25);
			zk_pkg::ZK_OP_SHA256_SIG0: result_o = rotr(a, 7) ^ rotr(a, 18) ^ (a >> 3);
			zk_pkg::ZK_OP_SHA256_SIG1: result_o = rotr(a, 17) ^ rotr(a, 19) ^ (a >> 10);
			// sm3 left rotations are written as the matching right rotations.
			zk_pkg::ZK_OP_SM3_P0:      result_o = a ^ rotr(a, `ZK_XLEN - 9) ^ rotr(a, `ZK_XLEN - 17);
			zk_pkg::ZK_OP_SM3_P1:      result_o = a ^ rotr(a, `ZK_XLEN - 15) ^ rotr(a, `ZK_XLEN - 23);
			default:                   result_o = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: hdl/zk_issue_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "zk_defs.svh"

module zk_issue_ctrl (
	input wire clk_i,
	input wire rst_i,
	input wire valid_i,
	input wire zk_pkg::zk_op_e operator_i,
	input wire [`ZK_XLEN-1:0] logic_res_i,
	input wire [`ZK_XLEN-1:0] perm_res_i,
	input wire [`ZK_XLEN-1:0] hash_res_i,
	output logic [`ZK_XLEN-1:0] result_o,
	output logic zk_val_o
);

	zk_pkg::zk_grp_e grp;
	logic [`ZK_XLEN-1:0] sel_res;
	logic legal;

	always_comb
	begin
		case (operator_i)
			zk_pkg::ZK_OP_ROR,
			zk_pkg::ZK_OP_ROL,
			zk_pkg::ZK_OP_RORI,
			zk_pkg::ZK_OP_ANDN,
			zk_pkg::ZK_OP_ORN,
			zk_pkg::ZK_OP_XNOR:        grp = zk_pkg::ZK_GRP_LOGIC;
			zk_pkg::ZK_OP_PACK,
			zk_pkg::ZK_OP_PACKH,
			zk_pkg::ZK_OP_BREV8,
			zk_pkg::ZK_OP_REV8,
			zk_pkg::ZK_OP_ZIP,
			zk_pkg::ZK_OP_UNZIP,
			zk_pkg::ZK_OP_XPERM4,
			zk_pkg::ZK_OP_XPERM8:      grp = zk_pkg::ZK_GRP_PERM;
			zk_pkg::ZK_OP_SHA256_SUM0,
			zk_pkg::ZK_OP_SHA256_SUM1,
			zk_pkg::ZK_OP_SHA256_SIG0,
			zk_pkg::ZK_OP_SHA256_SIG1,
			zk_pkg::ZK_OP_SM3_P0,
			zk_pkg::ZK_OP_SM3_P1:      grp = zk_pkg::ZK_GRP_HASH;
			default:                   grp = zk_pkg::ZK_GRP_NONE; // aes, sha512, sm4 and clmul land here.
		endcase
	end

	assign legal = (grp != zk_pkg::ZK_GRP_NONE);

	always_comb
	begin
		case (grp)
			zk_pkg::ZK_GRP_LOGIC: sel_res = logic_res_i;
			zk_pkg::ZK_GRP_PERM:  sel_res = perm_res_i;
			zk_pkg::ZK_GRP_HASH:  sel_res = hash_res_i;
			default:              sel_res = '0;
		endcase
	end

	// the single pipeline stage; outputs are overwritten every cycle.
	always_ff @(posedge clk_i)
	begin
		if (rst_i)
		begin
			result_o <= '0;
			zk_val_o <= 1'b0;
		end
		else
		begin
			result_o <= valid_i ? sel_res : '0; // idle cycles present a zero result.
			zk_val_o <= valid_i && legal;
		end
	end

endmodule

`default_nettype wire

// File: hdl/zk_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "zk_defs.svh"

module zk_unit (
	input wire clk_i,
	input wire rst_i,
	input wire valid_i,
	input wire zk_pkg::zk_op_e operator_i,
	input wire [`ZK_XLEN-1:0] operand_a_i,
	input wire [`ZK_XLEN-1:0] operand_b_i,
	output logic [`ZK_XLEN-1:0] result_o,
	output logic zk_val_o
);

	logic [`ZK_XLEN-1:0] logic_res;
	logic [`ZK_XLEN-1:0] perm_res;
	logic [`ZK_XLEN-1:0] hash_res;

	zk_rotate_logic u_rotate_logic (
		.operator_i  (operator_i),
		.operand_a_i (operand_a_i),
		.operand_b_i (operand_b_i),
		.result_o    (logic_res)
	);

	zk_permute u_permute (
		.operator_i  (operator_i),
		.operand_a_i (operand_a_i),
		.operand_b_i (operand_b_i),
		.result_o    (perm_res)
	);

	zk_hash_sigma u_hash_sigma (
		.operator_i  (operator_i),
		.operand_a_i (operand_a_i),
		.operand_b_i (operand_b_i),
		.result_o    (hash_res)
	);

	zk_issue_ctrl u_issue_ctrl (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.valid_i     (valid_i),
		.operator_i  (operator_i),
		.logic_res_i (logic_res),
		.perm_res_i  (perm_res),
		.hash_res_i  (hash_res),
		.result_o    (result_o),
		.zk_val_o    (zk_val_o)
	);

endmodule

`default_nettype wire

// File: verif/zk_assert.sv
`timescale 1ns/1ps
`default_nettype none

`include "zk_defs.svh"

module zk_assert (
	input wire clk_i,
	input wire rst_i,
	input wire valid_i,
	input wire [`ZK_XLEN-1:0] result_o,
	input wire zk_val_o
);

	int fail_cnt = 0;

	reset_clears_valid: assert property (@(posedge clk_i) rst_i |=> !zk_val_o)
	else
	begin
		$error("zk_val_o high in the cycle after reset");
		fail_cnt++;
	end

	valid_needs_issue: assert property (@(posedge clk_i) zk_val_o |-> $past(valid_i))
	else
	begin
		$error("zk_val_o high without valid_i one cycle earlier");
		fail_cnt++;
	end

	idle_result_zero: assert property (@(posedge clk_i) !zk_val_o |-> result_o == '0)
	else
	begin
		$error("result_o nonzero while zk_val_o is low");
		fail_cnt++;
	end

endmodule

bind zk_unit zk_assert u_assert (.*);

`default_nettype wire

// File: verif/zk_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "zk_defs.svh"

module zk_tb;

	localparam int N_RAND = 200;
	localparam int N_TRIP = 10;
	localparam int N_ILL = 100;
	localparam int RST_CYCLES = 4;
	localparam int TOTAL_OPS = 4*N_RAND + 4*N_TRIP + 32 + N_ILL + 20 + 15 + 6;
	localparam int WATCHDOG_NS = (TOTAL_OPS + RST_CYCLES + 20) * 40;

	logic clk_i = 1'b0;
	logic rst_i;
	logic valid_i;
	zk_pkg::zk_op_e operator_i;
	logic [`ZK_XLEN-1:0] operand_a_i;
	logic [`ZK_XLEN-1:0] operand_b_i;
	logic [`ZK_XLEN-1:0] result_o;
	logic zk_val_o;
	logic [31:0] lfsr_state = 32'd5;
	logic [`ZK_OP_W+`ZK_XLEN:0] exp_q [$]; // opcode, valid flag and result of the op in flight.
	int checks = 0;
	int errors = 0;
	int checks_mark = 0;
	int errors_mark = 0;
	// rotate and logic first, then the permutations, then the hash functions.
	zk_pkg::zk_op_e legal_ops [20] = '{
		zk_pkg::ZK_OP_ROR, zk_pkg::ZK_OP_ROL, zk_pkg::ZK_OP_RORI, zk_pkg::ZK_OP_ANDN,
		zk_pkg::ZK_OP_ORN, zk_pkg::ZK_OP_XNOR, zk_pkg::ZK_OP_PACK, zk_pkg::ZK_OP_PACKH,
		zk_pkg::ZK_OP_BREV8, zk_pkg::ZK_OP_REV8, zk_pkg::ZK_OP_ZIP, zk_pkg::ZK_OP_UNZIP,
		zk_pkg::ZK_OP_XPERM4, zk_pkg::ZK_OP_XPERM8, zk_pkg::ZK_OP_SHA256_SUM0,
		zk_pkg::ZK_OP_SHA256_SUM1, zk_pkg::ZK_OP_SHA256_SIG0, zk_pkg::ZK_OP_SHA256_SIG1,
		zk_pkg::ZK_OP_SM3_P0, zk_pkg::ZK_OP_SM3_P1};

	zk_unit uut (.*);

	always #20 clk_i = ~clk_i;

	// taps 32, 22, 2 and 1.
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		logic fb;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			r = {r[30:0], fb};
		end
		return r;
	endfunction

	function automatic logic legal_op(input logic [`ZK_OP_W-1:0] op);
		return (op >= 7'd62 && op <= 7'd73) || (op >= 7'd76 && op <= 7'd81) ||
			op == 7'd112 || op == 7'd113;
	endfunction

	function automatic logic [`ZK_XLEN-1:0] model(input logic [`ZK_OP_W-1:0] op,
		input logic [`ZK_XLEN-1:0] a, input logic [`ZK_XLEN-1:0] b);
		logic [2*`ZK_XLEN-1:0] aa;
		logic [`ZK_XLEN-1:0] r;
		int sh;
		aa = {a, a}; // a window of 32 bits at offset n is a rotated right by n.
		sh = b[4:0];
		r = '0;
		case (op)
			zk_pkg::ZK_OP_ROR,
			zk_pkg::ZK_OP_RORI: r = aa[sh +: 32];
			zk_pkg::ZK_OP_ROL:  r = aa[32 - sh +: 32];
			zk_pkg::ZK_OP_ANDN: r = a & ~b;
			zk_pkg::ZK_OP_ORN:  r = a | ~b;
			zk_pkg::ZK_OP_XNOR: r = ~(a ^ b);
			zk_pkg::ZK_OP_PACK: r = {b[15:0], a[15:0]};
			zk_pkg::ZK_OP_PACKH: r = {16'h0, b[7:0], a[7:0]};
			zk_pkg::ZK_OP_REV8: r = {a[7:0], a[15:8], a[23:16], a[31:24]};
			zk_pkg::ZK_OP_BREV8:
				for (int i = 0; i < 32; i++)
					r[i] = a[i ^ 7];
			zk_pkg::ZK_OP_ZIP:
				for (int i = 0; i < 32; i++)
					r[i] = a[i/2 + 16*(i%2)];
			zk_pkg::ZK_OP_UNZIP:
				for (int i = 0; i < 32; i++)
					r[i/2 + 16*(i%2)] = a[i];
			zk_pkg::ZK_OP_XPERM4:
				for (int i = 0; i < 8; i++)
					if (b[4*i +: 4] < 8)
						r[4*i +: 4] = a[4*b[4*i +: 4] +: 4];
			zk_pkg::ZK_OP_XPERM8:
				for (int i = 0; i < 4; i++)
					if (b[8*i +: 8] < 4)
						r[8*i +: 8] = a[8*b[8*i +: 8] +: 8];
			zk_pkg::ZK_OP_SHA256_SUM0: r = aa[2 +: 32] ^ aa[13 +: 32] ^ aa[22 +: 32];
			zk_pkg::ZK_OP_SHA256_SUM1: r = aa[6 +: 32] ^ aa[11 +: 32] ^ aa[25 +: 32];
			zk_pkg::ZK_OP_SHA256_SIG0: r = aa[7 +: 32] ^ aa[18 +: 32] ^ (a >> 3);
			zk_pkg::ZK_OP_SHA256_SIG1: r = aa[17 +: 32] ^ aa[19 +: 32] ^ (a >> 10);
			zk_pkg::ZK_OP_SM3_P0: r = a ^ aa[23 +: 32] ^ aa[15 +: 32]; // rol 9 and rol 17.
			zk_pkg::ZK_OP_SM3_P1: r = a ^ aa[17 +: 32] ^ aa[9 +: 32]; // rol 15 and rol 23.
			default: r = '0;
		endcase
		return r;
	endfunction

	task automatic check_result(input logic [`ZK_OP_W-1:0] op, input logic [`ZK_XLEN-1:0] exp,
		input logic [`ZK_XLEN-1:0] act);
		checks++;
		if (act !== exp)
		begin
			errors++;
			$display("** Error at time %0t: op %0d result expected %08h, got %08h",
				$time, op, exp, act);
		end
	endtask

	task automatic check_valid(input logic [`ZK_OP_W-1:0] op, input logic exp, input logic act);
		checks++;
		if (act !== exp)
		begin
			errors++;
			$display("** Error at time %0t: op %0d zk_val_o expected %b, got %b",
				$time, op, exp, act);
		end
	endtask

	// checks the op issued one cycle ago, then drives the next one.
	task automatic step(input logic rst, input logic v, input logic [`ZK_OP_W-1:0] op,
		input logic [`ZK_XLEN-1:0] a, input logic [`ZK_XLEN-1:0] b);
		logic [`ZK_OP_W+`ZK_XLEN:0] e;
		logic [`ZK_XLEN-1:0] r;
		logic ok;
		@(posedge clk_i);
		#2;
		if (exp_q.size() > 0)
		begin
			e = exp_q.pop_front();
			check_valid(e[`ZK_XLEN+1 +: `ZK_OP_W], e[`ZK_XLEN], zk_val_o);
			check_result(e[`ZK_XLEN+1 +: `ZK_OP_W], e[`ZK_XLEN-1:0], result_o);
		end
		ok = v && !rst && legal_op(op);
		r = ok ? model(op, a, b) : '0;
		rst_i = rst;
		valid_i = v;
		operator_i = zk_pkg::zk_op_e'(op);
		operand_a_i = a;
		operand_b_i = b;
		exp_q.push_back({op, ok, r});
	endtask

	task automatic random_ops(input int first, input int count, input int n, input logic sparse);
		logic [`ZK_OP_W-1:0] op;
		logic [`ZK_XLEN-1:0] a;
		logic [`ZK_XLEN-1:0] b;
		logic v;
		for (int i = 0; i < n; i++)
		begin
			op = legal_ops[first + rand_bits(5) % count];
			a = rand_bits(32);
			b = rand_bits(32);
			v = sparse ? 1'(rand_bits(1) | rand_bits(1)) : 1'b1;
			if (i < 16)
				b[4:0] = i[0] ? 5'd31 : 5'd0;
			if (op == zk_pkg::ZK_OP_XPERM8 && rand_bits(1) != 0)
				b = b & 32'h0303_0303; // most random byte indices are out of range.
			step(1'b0, v, op, a, b);
		end
	endtask

	task automatic report_test(input string name);
		step(1'b0, 1'b0, '0, '0, '0);
		$display("%-14s %0d checks, %0d errors", name, checks - checks_mark, errors - errors_mark);
		checks_mark = checks;
		errors_mark = errors;
	endtask

	initial
	begin
		logic [`ZK_OP_W-1:0] op;
		logic [`ZK_XLEN-1:0] a;
		logic [`ZK_XLEN-1:0] z;
		rst_i = 1'b1;
		valid_i = 1'b0;
		operator_i = zk_pkg::ZK_OP_ROR;
		operand_a_i = '0;
		operand_b_i = '0;
		repeat (RST_CYCLES - 1)
			step(1'b1, 1'b0, '0, '0, '0); // the first reset edge comes from the values above.
		random_ops(0, 6, N_RAND, 1'b0);
		report_test("rotate_logic");
		random_ops(6, 8, N_RAND, 1'b0);
		report_test("permute");
		random_ops(14, 6, N_RAND, 1'b0);
		for (int i = 0; i < N_TRIP; i++)
		begin
			a = rand_bits(32);
			step(1'b0, 1'b1, zk_pkg::ZK_OP_ZIP, a, '0);
			step(1'b0, 1'b0, '0, '0, '0);
			z = result_o;
			step(1'b0, 1'b1, zk_pkg::ZK_OP_UNZIP, z, '0);
			step(1'b0, 1'b0, '0, '0, '0);
			check_result(zk_pkg::ZK_OP_UNZIP, a, result_o);
		end
		report_test("hash");
		for (int i = 74; i < 112; i++)
			if (!legal_op(7'(i)))
				step(1'b0, 1'b1, 7'(i), rand_bits(32), rand_bits(32));
		for (int i = 0; i < N_ILL; i++)
		begin
			op = 7'(rand_bits(7));
			while (legal_op(op))
				op = 7'(rand_bits(7));
			step(1'b0, 1'b1, op, rand_bits(32), rand_bits(32));
		end
		report_test("illegal");
		for (int i = 0; i < 20; i++)
			step(1'b0, 1'b0, legal_ops[rand_bits(5) % 20], rand_bits(32), rand_bits(32));
		for (int i = 0; i < 5; i++)
		begin
			step(1'b0, 1'b1, legal_ops[i], rand_bits(32), rand_bits(32));
			step(1'b1, 1'b1, legal_ops[i + 6], rand_bits(32), rand_bits(32));
			step(1'b0, 1'b1, legal_ops[i + 14], rand_bits(32), rand_bits(32));
		end
		report_test("idle_reset");
		random_ops(0, 20, N_RAND, 1'b1);
		report_test("back_to_back");
		$display("total %0d checks, %0d errors, %0d assertion failures",
			checks, errors, uut.u_assert.fail_cnt);
		if (errors == 0 && uut.u_assert.fail_cnt == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
		$display("Test failures found");
		$finish;
	end

endmodule

`default_nettype wire

// File: tb.f
+incdir+hdl
hdl/zk_pkg.sv
hdl/zk_rotate_logic.sv
hdl/zk_permute.sv
hdl/zk_hash_sigma.sv
hdl/zk_issue_ctrl.sv
hdl/zk_unit.sv
verif/zk_assert.sv
verif/zk_tb.sv

// File: Bender.yml
package:
  name: zk_unit

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/zk_pkg.sv
      - hdl/zk_rotate_logic.sv
      - hdl/zk_permute.sv
      - hdl/zk_hash_sigma.sv
      - hdl/zk_issue_ctrl.sv
      - hdl/zk_unit.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - verif/zk_assert.sv
      - verif/zk_tb.sv
